// File: Makefile
VERILATOR ?= verilator
TOP       := cpu_tb
FILELIST  := compile.f
LINTFLAGS := --lint-only --timing -Wno-fatal
SIMFLAGS  := --binary --timing -Wno-fatal
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := ERRORS FOUND

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: compile.f
+incdir+logic
logic/cpu_pkg.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/mem_access.sv
logic/cpu_core.sv
tb/cpu_tb.sv

// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ******************************
// widths
// ******************************
`define CPU_DATA_W      16
`define CPU_PC_W        16
`define CPU_REG_COUNT   8
`define CPU_REG_ADDR_W  3
`define CPU_OP_W        5
`define CPU_FN_W        2

// ******************************
// major opcodes, bits 15..11
// ******************************
`define CPU_OP_LI       5'b01101
`define CPU_OP_ADDIU    5'b01001
`define CPU_OP_RR       5'b11100
`define CPU_OP_LW       5'b10011
`define CPU_OP_SW       5'b11011
`define CPU_OP_BEQZ     5'b00100
`define CPU_OP_BNEZ     5'b00101
`define CPU_OP_B        5'b00010

// function field of the register-register opcode
`define CPU_FN_ADDU     2'b01
`define CPU_FN_SUBU     2'b11
`define CPU_FN_AND      2'b00
`define CPU_FN_OR       2'b10

`endif

// File: logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic           clk_50MHz,
    input  logic           rst,
    output cpu_pkg::pc_t   inst_addr,
    input  cpu_pkg::inst_t inst,
    output logic           mem_req,
    output logic           mem_we,
    output cpu_pkg::data_t mem_addr,
    output cpu_pkg::data_t mem_wdata,
    input  cpu_pkg::data_t mem_rdata,
    input  logic           mem_ack
);

    // fetch
    cpu_pkg::pc_t       pc_q;
    cpu_pkg::pc_t       pc_plus1;

    // IF/ID
    cpu_pkg::inst_t     id_inst;
    cpu_pkg::pc_t       id_pc;
    cpu_pkg::reg_addr_t id_rx;
    cpu_pkg::reg_addr_t id_ry;

    // decode
    cpu_pkg::alu_op_e   dec_alu_op;
    cpu_pkg::b_sel_e    dec_b_sel;
    cpu_pkg::wb_sel_e   dec_wb_sel;
    cpu_pkg::branch_e   dec_branch;
    logic               dec_mem_we;
    logic               dec_mem_rd;
    cpu_pkg::reg_addr_t dec_dest;
    cpu_pkg::data_t     dec_imm;
    cpu_pkg::data_t     rf_ra_data;
    cpu_pkg::data_t     rf_rb_data;

    // ID/EX
    cpu_pkg::wb_sel_e   ex_wb_sel;
    cpu_pkg::branch_e   ex_branch;
    logic               ex_mem_we;
    logic               ex_mem_rd;
    cpu_pkg::alu_op_e   ex_alu_op;
    cpu_pkg::b_sel_e    ex_b_sel;
    cpu_pkg::reg_addr_t ex_dest;
    cpu_pkg::reg_addr_t ex_rx;
    cpu_pkg::reg_addr_t ex_ry;
    cpu_pkg::data_t     ex_imm;
    cpu_pkg::pc_t       ex_pc;
    cpu_pkg::data_t     ex_ra_data;
    cpu_pkg::data_t     ex_rb_data;

    // execute
    cpu_pkg::fwd_sel_e  fwd_a;
    cpu_pkg::fwd_sel_e  fwd_b;
    logic               load_stall;
    cpu_pkg::data_t     alu_result;
    cpu_pkg::data_t     store_data;
    logic               branch_taken;
    cpu_pkg::pc_t       branch_target;

    // EX/MEM
    cpu_pkg::wb_sel_e   mm_wb_sel;
    logic               mm_mem_we;
    logic               mm_mem_rd;
    logic               mm_wr;
    cpu_pkg::reg_addr_t mm_dest;
    cpu_pkg::data_t     mm_alu;
    cpu_pkg::data_t     mm_store;
    cpu_pkg::data_t     mm_rdata;
    logic               mem_busy;

    // MEM/WB
    cpu_pkg::wb_sel_e   wb_sel_q;
    logic               wb_wr;
    cpu_pkg::reg_addr_t wb_dest;
    cpu_pkg::data_t     wb_alu;
    cpu_pkg::data_t     wb_rdata;
    cpu_pkg::data_t     wb_data;

    assign inst_addr = pc_q;
    assign pc_plus1  = pc_q + 1'b1;
    assign id_rx     = id_inst[10:8];
    assign id_ry     = id_inst[7:5];
    assign mm_wr     = (mm_wb_sel != cpu_pkg::WB_NONE);
    assign wb_wr     = (wb_sel_q != cpu_pkg::WB_NONE);
    assign wb_data   = (wb_sel_q == cpu_pkg::WB_MEM) ? wb_rdata : wb_alu;

    // ******************************
    // stage logic
    // ******************************
    decode_unit decode_i (
        .inst(id_inst), .alu_op(dec_alu_op), .b_sel(dec_b_sel),
        .wb_sel(dec_wb_sel), .branch(dec_branch), .mem_we(dec_mem_we),
        .mem_rd(dec_mem_rd), .dest(dec_dest), .imm(dec_imm)
    );

    reg_file reg_file_i (
        .clk_50MHz(clk_50MHz), .rst(rst),
        .ra_addr(id_rx), .rb_addr(id_ry),
        .ra_data(rf_ra_data), .rb_data(rf_rb_data),
        .wr_en(wb_wr), .wr_addr(wb_dest), .wr_data(wb_data)
    );

    hazard_unit hazard_i (
        .ex_rx(ex_rx), .ex_ry(ex_ry), .mem_dest(mm_dest), .wb_dest(wb_dest),
        .mem_wr(mm_wr), .wb_wr(wb_wr), .mem_is_load(mm_mem_rd),
        .id_rx(id_rx), .id_ry(id_ry), .ex_dest(ex_dest), .ex_is_load(ex_mem_rd),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .load_stall(load_stall)
    );

    execute_unit execute_i (
        .op_a_reg(ex_ra_data), .op_b_reg(ex_rb_data),
        .mem_result(mm_alu), .wb_result(wb_data),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .imm(ex_imm), .pc(ex_pc),
        .alu_op(ex_alu_op), .b_sel(ex_b_sel), .branch(ex_branch),
        .alu_result(alu_result), .store_data(store_data),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    mem_access mem_access_i (
        .clk_50MHz(clk_50MHz), .rst(rst),
        .mem_rd_op(mm_mem_rd), .mem_we_op(mm_mem_we),
        .addr(mm_alu), .wdata(mm_store), .rdata_q(mm_rdata), .mem_busy(mem_busy),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

    // ******************************
    // pc and pipeline control
    // ******************************

    // priority is freeze, then branch flush, then load-use stall
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc_q      <= '0;
            id_inst   <= '0;
            ex_wb_sel <= cpu_pkg::WB_NONE;
            ex_branch <= cpu_pkg::BR_NONE;
            ex_mem_we <= 1'b0;
            ex_mem_rd <= 1'b0;
            mm_wb_sel <= cpu_pkg::WB_NONE;
            mm_mem_we <= 1'b0;
            mm_mem_rd <= 1'b0;
            wb_sel_q  <= cpu_pkg::WB_NONE;
        end else if (!mem_busy) begin
            if (branch_taken) begin
                pc_q    <= branch_target;
                id_inst <= '0;
            end else if (!load_stall) begin
                pc_q    <= pc_plus1;
                id_inst <= inst;
            end
            // bubble into execute on flush or stall
            if (branch_taken || load_stall) begin
                ex_wb_sel <= cpu_pkg::WB_NONE;
                ex_branch <= cpu_pkg::BR_NONE;
                ex_mem_we <= 1'b0;
                ex_mem_rd <= 1'b0;
            end else begin
                ex_wb_sel <= dec_wb_sel;
                ex_branch <= dec_branch;
                ex_mem_we <= dec_mem_we;
                ex_mem_rd <= dec_mem_rd;
            end
            mm_wb_sel <= ex_wb_sel;
            mm_mem_we <= ex_mem_we;
            mm_mem_rd <= ex_mem_rd;
            wb_sel_q  <= mm_wb_sel;
        end
    end

    // payload, only meaningful when the control above says so
    always_ff @(posedge clk_50MHz) begin
        if (!mem_busy) begin
            if (!load_stall) begin
                id_pc <= pc_plus1;
            end
            ex_alu_op  <= dec_alu_op;
            ex_b_sel   <= dec_b_sel;
            ex_dest    <= dec_dest;
            ex_rx      <= id_rx;
            ex_ry      <= id_ry;
            ex_imm     <= dec_imm;
            ex_pc      <= id_pc;
            ex_ra_data <= rf_ra_data;
            ex_rb_data <= rf_rb_data;
            mm_dest    <= ex_dest;
            mm_alu     <= alu_result;
            mm_store   <= store_data;
            wb_dest    <= mm_dest;
            wb_alu     <= mm_alu;
            wb_rdata   <= mm_rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    // ******************************
    // vector types
    // ******************************
    typedef logic [`CPU_DATA_W-1:0]     data_t;
    typedef logic [`CPU_DATA_W-1:0]     inst_t;
    typedef logic [`CPU_PC_W-1:0]       pc_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    // ******************************
    // decoder fields
    // ******************************
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS_B
    } alu_op_e;

    typedef enum logic {
        B_REG, B_IMM
    } b_sel_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_MEM
    } wb_sel_e;

    typedef enum logic [1:0] {
        BR_NONE, BR_EQZ, BR_NEZ, BR_ALWAYS
    } branch_e;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwd_sel_e;

    // data port handshake
    typedef enum logic [1:0] {
        MS_IDLE, MS_WAIT_ACK, MS_WAIT_LOW
    } mem_state_e;

endpackage

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module decode_unit (
    input  cpu_pkg::inst_t     inst,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::b_sel_e    b_sel,
    output cpu_pkg::wb_sel_e   wb_sel,
    output cpu_pkg::branch_e   branch,
    output logic               mem_we,
    output logic               mem_rd,
    output cpu_pkg::reg_addr_t dest,
    output cpu_pkg::data_t     imm
);

    logic [`CPU_OP_W-1:0] opcode;
    logic [`CPU_FN_W-1:0] fn;
    cpu_pkg::data_t       zext8;
    cpu_pkg::data_t       sext8;
    cpu_pkg::data_t       sext5;
    cpu_pkg::data_t       sext11;

    assign opcode = inst[15:11];
    assign fn     = inst[1:0];

    // immediate extender
    assign zext8  = {{(`CPU_DATA_W-8){1'b0}}, inst[7:0]};
    assign sext8  = {{(`CPU_DATA_W-8){inst[7]}}, inst[7:0]};
    assign sext5  = {{(`CPU_DATA_W-5){inst[4]}}, inst[4:0]};
    assign sext11 = {{(`CPU_DATA_W-11){inst[10]}}, inst[10:0]};

    always_comb begin
        // unknown opcodes and bubbles fall through as a no-op
        alu_op = cpu_pkg::ALU_ADD;
        b_sel  = cpu_pkg::B_REG;
        wb_sel = cpu_pkg::WB_NONE;
        branch = cpu_pkg::BR_NONE;
        mem_we = 1'b0;
        mem_rd = 1'b0;
        dest   = inst[10:8];
        imm    = sext8;

        case (opcode)
            `CPU_OP_LI: begin
                alu_op = cpu_pkg::ALU_PASS_B;
                b_sel  = cpu_pkg::B_IMM;
                wb_sel = cpu_pkg::WB_ALU;
                imm    = zext8;
            end
            `CPU_OP_ADDIU: begin
                b_sel  = cpu_pkg::B_IMM;
                wb_sel = cpu_pkg::WB_ALU;
            end
            `CPU_OP_RR: begin
                wb_sel = cpu_pkg::WB_ALU;
                dest   = inst[4:2];
                case (fn)
                    `CPU_FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    `CPU_FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    `CPU_FN_AND:  alu_op = cpu_pkg::ALU_AND;
                    `CPU_FN_OR:   alu_op = cpu_pkg::ALU_OR;
                endcase
            end
            // address is rx plus offset for both memory ops
            `CPU_OP_LW: begin
                b_sel  = cpu_pkg::B_IMM;
                wb_sel = cpu_pkg::WB_MEM;
                mem_rd = 1'b1;
                dest   = inst[7:5];
                imm    = sext5;
            end
            `CPU_OP_SW: begin
                b_sel  = cpu_pkg::B_IMM;
                mem_we = 1'b1;
                imm    = sext5;
            end
            `CPU_OP_BEQZ: branch = cpu_pkg::BR_EQZ;
            `CPU_OP_BNEZ: branch = cpu_pkg::BR_NEZ;
            `CPU_OP_B: begin
                branch = cpu_pkg::BR_ALWAYS;
                imm    = sext11;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  cpu_pkg::data_t    op_a_reg,
    input  cpu_pkg::data_t    op_b_reg,
    input  cpu_pkg::data_t    mem_result,
    input  cpu_pkg::data_t    wb_result,
    input  cpu_pkg::fwd_sel_e fwd_a,
    input  cpu_pkg::fwd_sel_e fwd_b,
    input  cpu_pkg::data_t    imm,
    input  cpu_pkg::pc_t      pc,
    input  cpu_pkg::alu_op_e  alu_op,
    input  cpu_pkg::b_sel_e   b_sel,
    input  cpu_pkg::branch_e  branch,
    output cpu_pkg::data_t    alu_result,
    output cpu_pkg::data_t    store_data,
    output logic              branch_taken,
    output cpu_pkg::pc_t      branch_target
);

    cpu_pkg::data_t op_a;
    cpu_pkg::data_t op_b_fwd;
    cpu_pkg::data_t alu_b;
    logic           a_zero;

    function automatic cpu_pkg::data_t fwd_mux(input cpu_pkg::fwd_sel_e sel,
                                               input cpu_pkg::data_t reg_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_result;
            cpu_pkg::FWD_WB:  return wb_result;
            default:          return reg_val;
        endcase
    endfunction

    // operand muxes
    always_comb begin
        op_a     = fwd_mux(fwd_a, op_a_reg);
        op_b_fwd = fwd_mux(fwd_b, op_b_reg);
    end
    assign alu_b = (b_sel == cpu_pkg::B_IMM) ? imm : op_b_fwd;

    // SW stores ry, never the offset
    assign store_data = op_b_fwd;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: alu_result = op_a + alu_b;
            cpu_pkg::ALU_SUB: alu_result = op_a - alu_b;
            cpu_pkg::ALU_AND: alu_result = op_a & alu_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | alu_b;
            default:          alu_result = alu_b;
        endcase
    end

    // ******************************
    // branch resolution
    // ******************************
    assign a_zero = (op_a == '0);

    always_comb begin
        case (branch)
            cpu_pkg::BR_EQZ:    branch_taken = a_zero;
            cpu_pkg::BR_NEZ:    branch_taken = !a_zero;
            cpu_pkg::BR_ALWAYS: branch_taken = 1'b1;
            default:            branch_taken = 1'b0;
        endcase
    end

    // pc already points past the branch
    assign branch_target = pc + imm;

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_addr_t ex_rx,
    input  cpu_pkg::reg_addr_t ex_ry,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  cpu_pkg::reg_addr_t wb_dest,
    input  logic               mem_wr,
    input  logic               wb_wr,
    input  logic               mem_is_load,
    input  cpu_pkg::reg_addr_t id_rx,
    input  cpu_pkg::reg_addr_t id_ry,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_is_load,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b,
    output logic               load_stall
);

    // ******************************
    // forwarding
    // ******************************

    // memory stage is younger, so it wins over write-back
    function automatic cpu_pkg::fwd_sel_e pick_src(input cpu_pkg::reg_addr_t src);
        cpu_pkg::fwd_sel_e sel;
        sel = cpu_pkg::FWD_REG;
        // load data is not ready in the memory stage yet
        if (mem_wr && !mem_is_load && mem_dest == src) begin
            sel = cpu_pkg::FWD_MEM;
        end else if (wb_wr && wb_dest == src) begin
            sel = cpu_pkg::FWD_WB;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rx);
        fwd_b = pick_src(ex_ry);
    end

    // ******************************
    // load-use
    // ******************************

    // one bubble, after which write-back forwarding covers the use
    assign load_stall = ex_is_load && (ex_dest == id_rx || ex_dest == id_ry);

endmodule

`default_nettype wire

// File: logic/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  logic           clk_50MHz,
    input  logic           rst,
    input  logic           mem_rd_op,
    input  logic           mem_we_op,
    input  cpu_pkg::data_t addr,
    input  cpu_pkg::data_t wdata,
    output cpu_pkg::data_t rdata_q,
    output logic           mem_busy,
    output logic           mem_req,
    output logic           mem_we,
    output cpu_pkg::data_t mem_addr,
    output cpu_pkg::data_t mem_wdata,
    input  cpu_pkg::data_t mem_rdata,
    input  logic           mem_ack
);

    cpu_pkg::mem_state_e state;
    logic                done;
    logic                access;

    assign access = mem_rd_op || mem_we_op;

    // stage is frozen while busy, so these hold for the whole handshake
    assign mem_we    = mem_we_op;
    assign mem_addr  = addr;
    assign mem_wdata = wdata;

    assign mem_busy = (state != cpu_pkg::MS_IDLE) || (access && !done);

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            state   <= cpu_pkg::MS_IDLE;
            mem_req <= 1'b0;
            done    <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::MS_IDLE: begin
                    if (access && !done) begin
                        mem_req <= 1'b1;
                        state   <= cpu_pkg::MS_WAIT_ACK;
                    end else begin
                        // not busy, stage moves on at this edge
                        done <= 1'b0;
                    end
                end
                cpu_pkg::MS_WAIT_ACK: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= cpu_pkg::MS_WAIT_LOW;
                    end
                end
                default: begin
                    if (!mem_ack) begin
                        state <= cpu_pkg::MS_IDLE;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // read data is valid while ack is high
    always_ff @(posedge clk_50MHz) begin
        if (state == cpu_pkg::MS_WAIT_ACK && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module reg_file (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t ra_addr,
    input  cpu_pkg::reg_addr_t rb_addr,
    output cpu_pkg::data_t     ra_data,
    output cpu_pkg::data_t     rb_data,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::data_t     wr_data
);

    cpu_pkg::data_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-through so decode sees the value written back this cycle
    assign ra_data = (wr_en && wr_addr == ra_addr) ? wr_data : regs[ra_addr];
    assign rb_data = (wr_en && wr_addr == rb_addr) ? wr_data : regs[rb_addr];

endmodule

`default_nettype wire

// File: tb/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;

    localparam cpu_pkg::inst_t halt_word = {`CPU_OP_B, 11'h7ff};

    logic           clk_50MHz;
    logic           rst;
    cpu_pkg::pc_t   inst_addr;
    cpu_pkg::inst_t inst;
    logic           mem_req;
    logic           mem_we;
    cpu_pkg::data_t mem_addr;
    cpu_pkg::data_t mem_wdata;
    cpu_pkg::data_t mem_rdata;
    logic           mem_ack;

    cpu_pkg::inst_t rom [256];
    cpu_pkg::data_t data_mem [256];
    cpu_pkg::data_t exp_addr [$];
    cpu_pkg::data_t exp_data [$];
    logic [31:0]    lfsr_state = 32'ha74a;
    int             prog_len = 0;
    int             errors = 0;
    int             checks = 0;
    int             store_idx = 0;
    int             timeout_cycles = 0;
    logic           req_q = 1'b0;
    logic           ack_q = 1'b0;

    cpu_core dut_i (
        .clk_50MHz(clk_50MHz), .rst(rst), .inst_addr(inst_addr), .inst(inst),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
    );

    initial clk_50MHz = 1'b0;
    always #10 clk_50MHz = ~clk_50MHz;

    // instruction ROM with no wait states
    assign inst = rom[inst_addr[7:0]];

    // ******************************
    // helpers
    // ******************************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit
    function automatic cpu_pkg::data_t take_bits(input int n);
        cpu_pkg::data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic cpu_pkg::data_t fill_word(input logic [7:0] a);
        return {a ^ 8'hc3, ~a};
    endfunction

    function automatic cpu_pkg::inst_t enc_imm(input logic [4:0] op, input logic [2:0] rx,
                                               input logic [7:0] imm);
        return {op, rx, imm};
    endfunction

    function automatic cpu_pkg::inst_t enc_mem(input logic [4:0] op, input logic [2:0] rx,
                                               input logic [2:0] ry, input logic [4:0] off);
        return {op, rx, ry, off};
    endfunction

    function automatic cpu_pkg::inst_t enc_rr(input logic [2:0] rx, input logic [2:0] ry,
                                              input logic [2:0] rz, input logic [1:0] fn);
        return {`CPU_OP_RR, rx, ry, rz, fn};
    endfunction

    function automatic cpu_pkg::inst_t enc_b(input logic [10:0] off);
        return {`CPU_OP_B, off};
    endfunction

    task automatic check_value(input cpu_pkg::data_t got, input cpu_pkg::data_t want,
                               input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic emit(input cpu_pkg::inst_t w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        cpu_pkg::data_t v1;
        cpu_pkg::data_t v2;
        cpu_pkg::data_t v3;
        v1 = take_bits(8);
        v2 = take_bits(8);
        v3 = take_bits(8);
        emit(enc_imm(`CPU_OP_LI, 3'd1, v1[7:0]));
        emit(enc_imm(`CPU_OP_LI, 3'd2, v2[7:0]));
        // dependent chain forwarding from the memory and write-back stages
        emit(enc_rr(3'd1, 3'd2, 3'd3, `CPU_FN_ADDU));
        emit(enc_rr(3'd3, 3'd1, 3'd4, `CPU_FN_SUBU));
        emit(enc_rr(3'd3, 3'd4, 3'd5, `CPU_FN_OR));
        emit(enc_imm(`CPU_OP_LI, 3'd7, 8'h40));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd5, 5'd0));
        emit(enc_rr(3'd5, 3'd2, 3'd6, `CPU_FN_AND));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd6, 5'd1));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd4, 5'd2));
        // load-use on rx and then on ry
        emit(enc_mem(`CPU_OP_LW, 3'd7, 3'd1, 5'd0));
        emit(enc_rr(3'd1, 3'd2, 3'd3, `CPU_FN_ADDU));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd3, 5'd3));
        emit(enc_mem(`CPU_OP_LW, 3'd7, 3'd4, 5'd5));
        emit(enc_rr(3'd2, 3'd4, 3'd6, `CPU_FN_ADDU));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd6, 5'd4));
        emit(enc_imm(`CPU_OP_ADDIU, 3'd6, v3[7:0]));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd6, 5'd6));
        emit(enc_mem(`CPU_OP_LW, 3'd7, 3'd2, 5'h1e));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd2, 5'h1f));
        // taken and untaken branches
        emit(enc_imm(`CPU_OP_LI, 3'd0, 8'h00));
        emit(enc_imm(`CPU_OP_BEQZ, 3'd0, 8'd2));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd2, 5'd7));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd2, 5'd8));
        emit(enc_imm(`CPU_OP_LI, 3'd5, 8'h01));
        emit(enc_imm(`CPU_OP_BEQZ, 3'd5, 8'd1));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd5, 5'd9));
        emit(enc_imm(`CPU_OP_BNEZ, 3'd5, 8'd1));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd5, 5'd10));
        emit(enc_imm(`CPU_OP_BNEZ, 3'd0, 8'd1));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd0, 5'd11));
        emit(enc_b(11'd1));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd1, 5'd12));
        // countdown loop of three passes
        emit(enc_imm(`CPU_OP_LI, 3'd4, 8'h03));
        emit(enc_imm(`CPU_OP_ADDIU, 3'd4, 8'hff));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd4, 5'd13));
        emit(enc_imm(`CPU_OP_BNEZ, 3'd4, 8'hfd));
        // branch right after a load
        emit(enc_mem(`CPU_OP_LW, 3'd7, 3'd3, 5'd13));
        emit(enc_imm(`CPU_OP_BEQZ, 3'd3, 8'd1));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd3, 5'd14));
        emit(enc_mem(`CPU_OP_SW, 3'd7, 3'd1, 5'd15));
        emit(halt_word);
    endtask

    // ******************************
    // reference model
    // ******************************

    // runs the program one instruction at a time and returns the step count
    function automatic int run_model();
        cpu_pkg::data_t regs [8];
        cpu_pkg::data_t dmem [256];
        cpu_pkg::data_t a;
        cpu_pkg::data_t b;
        cpu_pkg::data_t addr;
        cpu_pkg::inst_t iw;
        cpu_pkg::pc_t   pc;
        int             steps;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i[7:0]);
        end
        pc = '0;
        steps = 0;
        while (steps < 1000 && rom[pc[7:0]] != halt_word) begin
            iw = rom[pc[7:0]];
            a = regs[iw[10:8]];
            b = regs[iw[7:5]];
            addr = a + {{11{iw[4]}}, iw[4:0]};
            pc = pc + 16'd1;
            steps++;
            case (iw[15:11])
                `CPU_OP_LI:    regs[iw[10:8]] = {8'h00, iw[7:0]};
                `CPU_OP_ADDIU: regs[iw[10:8]] = a + {{8{iw[7]}}, iw[7:0]};
                `CPU_OP_RR: begin
                    case (iw[1:0])
                        `CPU_FN_ADDU: regs[iw[4:2]] = a + b;
                        `CPU_FN_SUBU: regs[iw[4:2]] = a - b;
                        `CPU_FN_AND:  regs[iw[4:2]] = a & b;
                        default:      regs[iw[4:2]] = a | b;
                    endcase
                end
                `CPU_OP_LW: regs[iw[7:5]] = dmem[addr[7:0]];
                `CPU_OP_SW: begin
                    dmem[addr[7:0]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                `CPU_OP_BEQZ: if (a == 16'h0) pc = pc + {{8{iw[7]}}, iw[7:0]};
                `CPU_OP_BNEZ: if (a != 16'h0) pc = pc + {{8{iw[7]}}, iw[7:0]};
                `CPU_OP_B:    pc = pc + {{5{iw[10]}}, iw[10:0]};
                default: ;
            endcase
        end
        return steps;
    endfunction

    // ******************************
    // memory responder
    // ******************************
    initial begin : responder
        int delay;
        forever begin
            @(negedge clk_50MHz);
            if (rst && mem_req && !mem_ack) begin
                delay = int'(take_bits(2));
                repeat (delay) @(negedge clk_50MHz);
                @(posedge clk_50MHz);
                #2;
                if (mem_we) begin
                    data_mem[mem_addr[7:0]] = mem_wdata;
                end else begin
                    mem_rdata = data_mem[mem_addr[7:0]];
                end
                mem_ack = 1'b1;
                do @(negedge clk_50MHz); while (mem_req);
                delay = int'(take_bits(2));
                repeat (delay) @(negedge clk_50MHz);
                @(posedge clk_50MHz);
                #2;
                mem_ack = 1'b0;
            end
        end
    end

    // store comparison and handshake order
    always @(negedge clk_50MHz) begin
        if (!rst) begin
            check_value(inst_addr, 16'h0000, "inst_addr in reset");
            check_value({15'd0, mem_req}, 16'h0000, "mem_req in reset");
        end else begin
            if (mem_req && !req_q && mem_ack) begin
                errors++;
                $display("mem_req rose at %0t ns before the previous ack had fallen", $time);
            end
            if (mem_ack && !ack_q && mem_we) begin
                if (store_idx < exp_addr.size()) begin
                    check_value(mem_addr, exp_addr[store_idx], "store address");
                    check_value(mem_wdata, exp_data[store_idx], "store data");
                end else begin
                    errors++;
                    $display("store of %h to %h at %0t ns is more than the program makes",
                             mem_wdata, mem_addr, $time);
                end
                store_idx++;
            end
        end
        req_q = mem_req;
        ack_q = mem_ack;
    end

    initial begin : watchdog
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk_50MHz);
        $display("timeout after %0d cycles, the core hung with %0d of %0d stores seen",
                 timeout_cycles, store_idx, exp_addr.size());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main_flow
        rst = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
            data_mem[i] = fill_word(i[7:0]);
        end
        build_program();
        timeout_cycles = (run_model() + 8) * 40;
        repeat (8) @(posedge clk_50MHz);
        #2;
        rst = 1'b1;
        @(negedge clk_50MHz);
        check_value(inst_addr, 16'h0000, "first fetch address");
        check_value({15'd0, mem_req}, 16'h0000, "mem_req after reset");
        while (store_idx < exp_addr.size()) begin
            @(negedge clk_50MHz);
        end
        // the halt loop runs on and must make no further stores
        repeat (30) @(negedge clk_50MHz);
        check_value(store_idx[15:0], 16'(exp_addr.size()), "store count");
        $display("checks %0d, errors %0d, stores %0d of %0d",
                 checks, errors, store_idx, exp_addr.size());
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
